// File: common/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// ********************************************************
// sizing of the descriptor write-back engine
// ********************************************************

// width of every host memory address, including the block addresses
// handed over by the fetch side and the readable current location
`define WB_ADDR_WIDTH 32

// log2 of the depth of both the descriptor queue and the response queue
// so each of them holds 16 entries and reports a fill level of 0 to 16
`define WB_FIFO_DEPTH_LOG2 4

// size of one merged write-back record in bytes
// each record goes out as one beat so this is also the step
// of the address counter from one write to the next
`define WB_RECORD_BYTES 32

// a descriptor block is a run of records at consecutive addresses
// which ends with the record whose descriptor has format bit 1 set
// after that record the engine moves to the next block address
// and the software side sees the jump on the current location
// only the fields that the merge uses are kept in the descriptor
// so the record fits a single 256 bit beat with room to spare

`endif

// File: common/wb_pkg.sv
package wb_pkg;

  `include "wb_settings.svh"

  // ********************************************************
  // descriptor as dispatched to the DMA
  // ********************************************************

  // format bit 1 marks the last descriptor of its block
  typedef struct packed
  {
    logic [31:0] length;        // bytes to move
    logic [31:0] destination;   // write side address of the transfer
    logic [31:0] source;        // read side address of the transfer
    logic [15:0] sequence_num;  // lets software match records to descriptors
    logic [7:0]  control;       // passed through untouched
    logic [4:0]  reserved;
    logic        owned_by_hw;   // software hands a descriptor over by setting this
    logic [1:0]  format;
  } descriptor_t;  // 128 bits

  // ********************************************************
  // completion response from the dispatcher
  // ********************************************************

  typedef struct packed
  {
    logic        eop_irq_mask;                // interrupt when eop_arrived is set
    logic        early_termination_irq_mask;  // interrupt on early termination
    logic [7:0]  error_irq_mask;              // one enable per error bit
    logic        transfer_complete_irq_mask;  // interrupt on every completion
    logic        early_termination;
    logic        eop_arrived;                 // packet end seen on the stream
    logic [7:0]  error;
    logic [31:0] actual_bytes;                // bytes that really moved
  } response_t;  // 53 bits

  // ********************************************************
  // merged record written back to host memory
  // ********************************************************

  // the descriptor half sits in the low 128 bits just as it was fetched
  typedef struct packed
  {
    logic [85:0] padding;            // always zero
    logic        early_termination;
    logic        eop_arrived;
    logic [7:0]  error;
    logic [31:0] actual_bytes;
    logic [31:0] length;
    logic [31:0] destination;
    logic [31:0] source;
    logic [15:0] sequence_num;
    logic [7:0]  control;
    logic [4:0]  reserved;
    logic        owned_by_hw;        // cleared so software sees the descriptor back
    logic [1:0]  format;
  } wb_record_t;  // 256 bits

  // single beat write towards host memory
  typedef struct packed
  {
    logic                      write;
    logic [`WB_ADDR_WIDTH-1:0] address;
    wb_record_t                data;
  } mem_write_t;

  // states of the block FSM in the sequencer
  typedef enum logic [1:0]
  {
    idle        = 2'b00,
    load_block  = 2'b01,
    store_block = 2'b10
  } seq_state_e;

endpackage

// File: design/sync_fifo.sv
`timescale 1ns/100ps

// show-ahead FIFO whose head entry is valid whenever empty is low
module sync_fifo
#(
  parameter int width      = 8,
  parameter int depth_log2 = 4
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic [width-1:0]      push_data,
  input  logic                  push_valid,
  output logic                  push_ready,
  input  logic                  pop,
  output logic [width-1:0]      head,
  output logic                  empty,
  output logic [depth_log2:0]   fill_level
);

  localparam logic [depth_log2:0] depth = 1 << depth_log2;  // entries in the buffer

  logic [width-1:0]      mem [depth];
  logic [depth_log2-1:0] wr_ptr;  // next slot to fill
  logic [depth_log2-1:0] rd_ptr;  // slot shown on head
  logic [depth_log2:0]   count;   // one bit wider than the pointers so full can be told from empty
  logic                  do_push;
  logic                  do_pop;

  assign push_ready = (count != depth);  // room for one more entry
  assign empty      = (count == '0);
  assign do_push    = push_valid & push_ready;
  assign do_pop     = pop & ~empty;       // a pop on an empty queue is ignored

  // ********************************************************
  // storage
  // ********************************************************

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign head = mem[rd_ptr];  // read is combinational so the head shows ahead of the pop

  // ********************************************************
  // pointers and count
  // ********************************************************

  always_ff @(posedge clk)
  begin
    if (reset | flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at the end of the buffer
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // push and pop together leave the level unchanged
      endcase
    end
  end

  assign fill_level = count;

endmodule

// File: writeback/writeback_sequencer.sv
`timescale 1ns/100ps
`include "wb_settings.svh"

module writeback_sequencer
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      enable_store,
  input  logic                      flush,
  input  logic [`WB_ADDR_WIDTH-1:0] block_address,
  input  logic                      block_address_valid,
  output logic                      block_address_ready,
  input  wb_pkg::descriptor_t       desc_head,
  input  logic                      desc_empty,
  input  wb_pkg::response_t         resp_head,
  input  logic                      resp_empty,
  output logic                      pop,
  output wb_pkg::mem_write_t        mem_write,
  input  logic                      waitrequest,
  output logic [`WB_ADDR_WIDTH-1:0] current_location
);

  import wb_pkg::*;

  localparam logic [`WB_ADDR_WIDTH-1:0] addr_step = `WB_RECORD_BYTES;  // one record per write

  seq_state_e                state;
  logic                      write_req;        // both heads present while storing
  logic                      accept;           // memory took the write this cycle
  logic                      last_in_block;    // accepted write closes the block
  logic [`WB_ADDR_WIDTH-1:0] address_counter;
  wb_record_t                record;

  assign write_req     = (state == store_block) & ~desc_empty & ~resp_empty;
  assign accept        = write_req & ~waitrequest;
  assign last_in_block = accept & desc_head.format[1];
  assign pop           = accept;  // both queues drop their head together

  // ********************************************************
  // block FSM
  // ********************************************************

  // idle waits for a block address, load_block takes it in one cycle
  // and store_block writes records until the last one of the block
  always_ff @(posedge clk)
  begin
    if (reset | flush | ~enable_store)
    begin
      state <= idle;  // software stops and restarts the engine from here
    end
    else
    begin
      case (state)
        idle:
        begin
          if (block_address_valid)
          begin
            state <= load_block;
          end
        end
        load_block:
        begin
          state <= store_block;  // single cycle while the counter loads
        end
        store_block:
        begin
          if (last_in_block)
          begin
            // go straight on to the next block if its address is already waiting
            state <= block_address_valid ? load_block : idle;
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  // the source holds block_address_valid until this strobe
  assign block_address_ready = (state == load_block);

  // ********************************************************
  // address counter
  // ********************************************************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      address_counter <= '0;
    end
    else if (state == load_block)
    begin
      address_counter <= block_address;  // start of the new block
    end
    else if (accept)
    begin
      address_counter <= address_counter + addr_step;
    end
  end

  assign current_location = address_counter;  // readable by software

  // ********************************************************
  // merge and memory write
  // ********************************************************

  always_comb
  begin
    record                   = '0;  // padding stays zero
    record.format            = desc_head.format;
    record.owned_by_hw       = 1'b0;  // ownership goes back to software
    record.reserved          = desc_head.reserved;
    record.control           = desc_head.control;
    record.sequence_num      = desc_head.sequence_num;
    record.source            = desc_head.source;
    record.destination       = desc_head.destination;
    record.length            = desc_head.length;
    record.actual_bytes      = resp_head.actual_bytes;
    record.error             = resp_head.error;
    record.eop_arrived       = resp_head.eop_arrived;
    record.early_termination = resp_head.early_termination;
  end

  // heads and counter only move on accept so the write holds under waitrequest
  always_comb
  begin
    mem_write.write   = write_req;
    mem_write.address = address_counter;
    mem_write.data    = record;
  end

endmodule

// File: design/completion_irq.sv
`timescale 1ns/100ps

module completion_irq
(
  input  logic              clk,
  input  logic              reset,
  input  logic              accept,        // write of the head record taken by memory
  input  wb_pkg::response_t resp_head,     // response that belongs to that record
  input  logic              sw_clear_irq,  // one cycle strobe from software
  input  logic              irq_mask,
  output logic              irq
);

  logic irq_flag;  // sticky until software clears it
  logic irq_d1;
  logic irq_d2;
  logic set_irq;

  // any enabled status bit of the completed transfer requests an interrupt
  assign set_irq = accept &
                   (resp_head.transfer_complete_irq_mask |
                    ((resp_head.error_irq_mask & resp_head.error) != 8'h00) |
                    (resp_head.early_termination_irq_mask & resp_head.early_termination) |
                    (resp_head.eop_irq_mask & resp_head.eop_arrived));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      irq_flag <= 1'b0;
      irq_d1   <= 1'b0;
      irq_d2   <= 1'b0;
    end
    else
    begin
      if (sw_clear_irq)
      begin
        irq_flag <= 1'b0;  // clear wins over a set in the same cycle
      end
      else if (set_irq)
      begin
        irq_flag <= 1'b1;
      end
      irq_d1 <= irq_flag;  // two stages give the record time to land in memory
      irq_d2 <= irq_d1;
    end
  end

  assign irq = irq_d2 & irq_mask;  // the mask acts at once

endmodule

// File: design/desc_writeback_top.sv
`timescale 1ns/100ps
`include "wb_settings.svh"

module desc_writeback_top
(
  input  logic                          clk,
  input  logic                          reset,
  output wb_pkg::mem_write_t            mem_write,
  input  logic                          waitrequest,
  input  logic [`WB_ADDR_WIDTH-1:0]     block_address,
  input  logic                          block_address_valid,
  output logic                          block_address_ready,
  input  wb_pkg::descriptor_t           descriptor,
  input  logic                          descriptor_valid,
  output logic                          descriptor_ready,
  input  wb_pkg::response_t             response,
  input  logic                          response_valid,
  output logic                          response_ready,
  output logic                          irq,
  input  logic                          sw_clear_irq,
  input  logic                          irq_mask,
  input  logic                          enable_store,
  input  logic                          flush,
  output logic [`WB_ADDR_WIDTH-1:0]     current_location,
  output logic [`WB_FIFO_DEPTH_LOG2:0]  descriptor_fill_level,
  output logic [`WB_FIFO_DEPTH_LOG2:0]  response_fill_level
);

  import wb_pkg::*;

  descriptor_t desc_head;   // oldest dispatched descriptor
  response_t   resp_head;   // oldest completion response
  logic        desc_empty;
  logic        resp_empty;
  logic        pop;         // accept strobe of the memory write

  // ********************************************************
  // queues for descriptors in flight and their responses
  // ********************************************************

  sync_fifo #(
    .width      ($bits(descriptor_t)),
    .depth_log2 (`WB_FIFO_DEPTH_LOG2)
  ) u_desc_fifo (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .push_data  (descriptor),
    .push_valid (descriptor_valid),
    .push_ready (descriptor_ready),
    .pop        (pop),
    .head       (desc_head),
    .empty      (desc_empty),
    .fill_level (descriptor_fill_level)
  );

  sync_fifo #(
    .width      ($bits(response_t)),
    .depth_log2 (`WB_FIFO_DEPTH_LOG2)
  ) u_resp_fifo (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .push_data  (response),
    .push_valid (response_valid),
    .push_ready (response_ready),
    .pop        (pop),      // pops in step with the descriptor queue
    .head       (resp_head),
    .empty      (resp_empty),
    .fill_level (response_fill_level)
  );

  // ********************************************************
  // record writer and interrupt
  // ********************************************************

  writeback_sequencer u_sequencer (
    .clk                 (clk),
    .reset               (reset),
    .enable_store        (enable_store),
    .flush               (flush),
    .block_address       (block_address),
    .block_address_valid (block_address_valid),
    .block_address_ready (block_address_ready),
    .desc_head           (desc_head),
    .desc_empty          (desc_empty),
    .resp_head           (resp_head),
    .resp_empty          (resp_empty),
    .pop                 (pop),
    .mem_write           (mem_write),
    .waitrequest         (waitrequest),
    .current_location    (current_location)
  );

  completion_irq u_irq (
    .clk          (clk),
    .reset        (reset),
    .accept       (pop),
    .resp_head    (resp_head),
    .sw_clear_irq (sw_clear_irq),
    .irq_mask     (irq_mask),
    .irq          (irq)
  );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

// free running clock for the testbench and a reset that covers the first cycles
module tb_clock_gen
(
  output logic clk,
  output logic reset
);

  localparam int reset_cycles = 16;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;  // 4 ns period
    end
  end

  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;  // released just after the edge like every other input
  end

endmodule

// File: testbench/desc_writeback_tb.sv
`timescale 1ns/100ps
`include "wb_settings.svh"

module desc_writeback_tb;

  import wb_pkg::*;

  // the tests need well under a thousand cycles together so this leaves a wide margin
  localparam int cycle_limit = 20000;
  localparam int wait_limit  = 500;  // longest wait for the writes of one test

  logic                         clk;
  logic                         reset;
  mem_write_t                   mem_write;
  logic                         waitrequest;
  logic [`WB_ADDR_WIDTH-1:0]    block_address;
  logic                         block_address_valid;
  logic                         block_address_ready;
  descriptor_t                  descriptor;
  logic                         descriptor_valid;
  logic                         descriptor_ready;
  response_t                    response;
  logic                         response_valid;
  logic                         response_ready;
  logic                         irq;
  logic                         sw_clear_irq;
  logic                         irq_mask;
  logic                         enable_store;
  logic                         flush;
  logic [`WB_ADDR_WIDTH-1:0]    current_location;
  logic [`WB_FIFO_DEPTH_LOG2:0] descriptor_fill_level;
  logic [`WB_FIFO_DEPTH_LOG2:0] response_fill_level;

  logic [31:0] addr_queue [$];  // block addresses still to be offered to the DUT
  logic [31:0] log_addr [$];    // address of every accepted write in order
  wb_record_t  log_data [$];
  logic [31:0] exp_addr [$];    // what the running test expects to see written
  wb_record_t  exp_data [$];
  logic        random_wait;
  logic        addr_handshake = 1'b0;
  logic        stall_pending  = 1'b0;  // a write was held off by waitrequest last cycle
  mem_write_t  held_write;
  int          error_count    = 0;
  int          stall_errors   = 0;     // counted by the memory model
  int          tests_failed   = 0;
  int          cycle_count    = 0;
  int          next_seq       = 0;

  tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

  desc_writeback_top DUT (
    .clk                   (clk),
    .reset                 (reset),
    .mem_write             (mem_write),
    .waitrequest           (waitrequest),
    .block_address         (block_address),
    .block_address_valid   (block_address_valid),
    .block_address_ready   (block_address_ready),
    .descriptor            (descriptor),
    .descriptor_valid      (descriptor_valid),
    .descriptor_ready      (descriptor_ready),
    .response              (response),
    .response_valid        (response_valid),
    .response_ready        (response_ready),
    .irq                   (irq),
    .sw_clear_irq          (sw_clear_irq),
    .irq_mask              (irq_mask),
    .enable_store          (enable_store),
    .flush                 (flush),
    .current_location      (current_location),
    .descriptor_fill_level (descriptor_fill_level),
    .response_fill_level   (response_fill_level)
  );

  // ********************************************************
  // background drivers, memory model and timeout
  // ********************************************************

  // block addresses go out one at a time and each is held until ready was seen
  initial
  begin
    block_address       = '0;
    block_address_valid = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      if (addr_handshake)
      begin
        block_address_valid = 1'b0;
      end
      if (!block_address_valid && addr_queue.size() > 0)
      begin
        block_address       = addr_queue.pop_front();
        block_address_valid = 1'b1;
      end
    end
  end

  initial
  begin
    waitrequest = 1'b0;
    forever
    begin
      @(posedge clk);
      #1 waitrequest = random_wait && ($urandom % 2 == 0);  // stalls about half the cycles
    end
  end

  // the memory samples mid cycle, a write seen here is taken on the next rising edge
  always @(negedge clk)
  begin
    addr_handshake = block_address_valid & block_address_ready;
    if (stall_pending)
    begin
      assert (mem_write.write)
      else
      begin
        $display("Write was withdrawn at %0t while waitrequest was high", $time);
        stall_errors++;
      end
      assert (mem_write.address === held_write.address)
      else
      begin
        $display("Error at %0t: mem_write.address is %h, expected %h", $time,
                 mem_write.address, held_write.address);
        stall_errors++;
      end
      assert (mem_write.data === held_write.data)
      else
      begin
        $display("Error at %0t: mem_write.data is %h, expected %h", $time,
                 mem_write.data, held_write.data);
        stall_errors++;
      end
    end
    if (mem_write.write && !waitrequest)
    begin
      log_addr.push_back(mem_write.address);
      log_data.push_back(mem_write.data);
    end
    stall_pending = mem_write.write & waitrequest;
    held_write    = mem_write;
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("Run stopped after %0d cycles before the tests were done", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ********************************************************
  // helpers
  // ********************************************************

  function automatic int total_errors();
    return error_count + stall_errors;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;  // inputs change just after the edge
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want)
    else
    begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    assert (got === want)
    else
    begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, want);
      error_count++;
    end
  endtask

  function automatic descriptor_t make_descriptor(input logic last);
    descriptor_t d;
    logic [31:0] rnd;
    rnd            = $urandom;
    d.format       = {last, rnd[0]};
    d.owned_by_hw  = 1'b1;  // must come back cleared
    d.reserved     = rnd[20:16];
    d.control      = rnd[15:8];
    d.sequence_num = 16'(next_seq);
    d.source       = $urandom;
    d.destination  = $urandom;
    d.length       = $urandom;
    return d;
  endfunction

  // status bits are random and of the mask bits only transfer complete is ever set
  function automatic response_t make_response(input logic complete_mask);
    response_t   r;
    logic [31:0] rnd;
    rnd                          = $urandom;
    r                            = '0;
    r.actual_bytes               = $urandom;
    r.error                      = rnd[7:0];
    r.eop_arrived                = rnd[8];
    r.early_termination          = rnd[9];
    r.transfer_complete_irq_mask = complete_mask;
    return r;
  endfunction

  // 86 zero bits on top, then the response status, then the descriptor given back
  function automatic wb_record_t expected_record(input descriptor_t d, input response_t r);
    descriptor_t returned;
    returned             = d;
    returned.owned_by_hw = 1'b0;
    return {86'd0, r.early_termination, r.eop_arrived, r.error, r.actual_bytes, returned};
  endfunction

  task automatic push_descriptor(input descriptor_t d);
    descriptor       = d;
    descriptor_valid = 1'b1;
    @(negedge clk);
    while (!descriptor_ready)
    begin
      @(negedge clk);
    end
    next_cycle();
    descriptor_valid = 1'b0;
  endtask

  task automatic push_response(input response_t r);
    response       = r;
    response_valid = 1'b1;
    @(negedge clk);
    while (!response_ready)
    begin
      @(negedge clk);
    end
    next_cycle();
    response_valid = 1'b0;
  endtask

  // slot is the position of the record inside its block
  task automatic push_pair(input logic [31:0] base, input int slot, input logic last,
                           input logic complete_mask);
    descriptor_t d;
    response_t   r;
    d = make_descriptor(last);
    r = make_response(complete_mask);
    next_seq++;
    push_descriptor(d);
    push_response(r);
    exp_addr.push_back(base + 32'(slot * `WB_RECORD_BYTES));
    exp_data.push_back(expected_record(d, r));
  endtask

  // returns just after the accept edge of the last write asked for
  task automatic wait_for_writes(input int count);
    int waited;
    waited = 0;
    while (log_addr.size() < count && waited < wait_limit)
    begin
      next_cycle();
      waited++;
    end
    assert (log_addr.size() >= count)
    else
    begin
      $display("Only %0d of %0d writes arrived within %0d cycles", log_addr.size(), count,
               wait_limit);
      error_count++;
    end
  endtask

  task automatic compare_writes(input int first);
    repeat (8)
    begin
      next_cycle();  // a stray extra write gets time to show up
    end
    for (int i = 0; i < exp_addr.size(); i++)
    begin
      if (first + i < log_addr.size())
      begin
        check_word("mem_write.address", log_addr[first + i], exp_addr[i]);
        assert (log_data[first + i] === exp_data[i])
        else
        begin
          $display("Error at %0t: mem_write.data is %h, expected %h", $time,
                   log_data[first + i], exp_data[i]);
          error_count++;
        end
      end
    end
    check_word("number of writes", 32'(log_addr.size() - first), 32'(exp_addr.size()));
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic finish_test(input string name, input int start);
    int found;
    found = total_errors() - start;
    if (found == 0)
    begin
      $display("test %s passed", name);
    end
    else
    begin
      $display("test %s failed with %0d errors", name, found);
      tests_failed++;
    end
  endtask

  // ********************************************************
  // directed tests
  // ********************************************************

  task automatic test_single_block();
    int start;
    int first;
    start = total_errors();
    first = log_addr.size();
    check_bit("mem_write.write", mem_write.write, 1'b0);  // state right after reset
    check_bit("block_address_ready", block_address_ready, 1'b0);
    check_bit("irq", irq, 1'b0);
    check_word("descriptor_fill_level", 32'(descriptor_fill_level), 32'd0);
    check_word("response_fill_level", 32'(response_fill_level), 32'd0);
    enable_store = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      push_pair(32'h0001_0000, i, i == 3, 1'b0);
    end
    addr_queue.push_back(32'h0001_0000);
    wait_for_writes(first + 4);
    check_word("current_location", current_location, 32'h0001_0080);
    compare_writes(first);
    finish_test("single block", start);
  endtask

  task automatic test_consecutive_blocks();
    int start;
    int first;
    start = total_errors();
    first = log_addr.size();
    addr_queue.push_back(32'h0002_0000);  // second address waits while the first block runs
    addr_queue.push_back(32'h0003_0000);
    for (int i = 0; i < 3; i++)
    begin
      push_pair(32'h0002_0000, i, i == 2, 1'b0);
    end
    for (int i = 0; i < 3; i++)
    begin
      push_pair(32'h0003_0000, i, i == 2, 1'b0);
    end
    wait_for_writes(first + 6);
    check_word("current_location", current_location, 32'h0003_0060);
    compare_writes(first);
    finish_test("consecutive blocks", start);
  endtask

  task automatic test_back_pressure();
    int start;
    int first;
    start       = total_errors();
    first       = log_addr.size();
    random_wait = 1'b1;  // the memory model checks that stalled writes hold still
    addr_queue.push_back(32'h0004_0000);
    for (int i = 0; i < 8; i++)
    begin
      push_pair(32'h0004_0000, i, i == 7, 1'b0);
    end
    wait_for_writes(first + 8);
    random_wait = 1'b0;
    compare_writes(first);
    finish_test("back pressure", start);
  endtask

  task automatic test_pairing();
    int          start;
    int          first;
    descriptor_t d;
    response_t   r;
    start = total_errors();
    first = log_addr.size();
    d     = make_descriptor(1'b1);
    r     = make_response(1'b0);
    next_seq++;
    addr_queue.push_back(32'h0005_0000);
    push_descriptor(d);
    repeat (20)
    begin
      next_cycle();
    end
    check_bit("mem_write.write", mem_write.write, 1'b0);  // no response yet so nothing to write
    check_word("number of writes", 32'(log_addr.size() - first), 32'd0);
    check_word("descriptor_fill_level", 32'(descriptor_fill_level), 32'd1);
    check_word("response_fill_level", 32'(response_fill_level), 32'd0);
    push_response(r);
    exp_addr.push_back(32'h0005_0000);
    exp_data.push_back(expected_record(d, r));
    wait_for_writes(first + 1);
    compare_writes(first);
    finish_test("pairing", start);
  endtask

  task automatic test_interrupt();
    int start;
    int first;
    start    = total_errors();
    first    = log_addr.size();
    irq_mask = 1'b1;
    addr_queue.push_back(32'h0006_0000);
    push_pair(32'h0006_0000, 0, 1'b1, 1'b1);
    wait_for_writes(first + 1);
    // the flag is set on the accept edge and then passes two delay stages
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    @(negedge clk);
    check_bit("irq", irq, 1'b1);
    next_cycle();
    irq_mask = 1'b0;
    @(negedge clk);
    check_bit("irq", irq, 1'b0);  // the mask acts without delay
    next_cycle();
    irq_mask = 1'b1;
    @(negedge clk);
    check_bit("irq", irq, 1'b1);
    next_cycle();
    sw_clear_irq = 1'b1;
    next_cycle();
    sw_clear_irq = 1'b0;
    @(negedge clk);
    check_bit("irq", irq, 1'b1);
    @(negedge clk);
    check_bit("irq", irq, 1'b1);
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    compare_writes(first);
    // status bits may be set but with every mask bit clear nothing is raised
    first = log_addr.size();
    addr_queue.push_back(32'h0007_0000);
    push_pair(32'h0007_0000, 0, 1'b1, 1'b0);
    wait_for_writes(first + 1);
    repeat (6)
    begin
      @(negedge clk);
      check_bit("irq", irq, 1'b0);
    end
    compare_writes(first);
    finish_test("interrupt", start);
  endtask

  task automatic test_fill_and_flush();
    int start;
    int first;
    start        = total_errors();
    first        = log_addr.size();
    enable_store = 1'b0;
    addr_queue.push_back(32'h0008_0000);  // offered but never taken while storing is off
    for (int i = 0; i < 16; i++)
    begin
      push_descriptor(make_descriptor(1'b0));
      next_seq++;
    end
    for (int i = 0; i < 16; i++)
    begin
      push_response(make_response(1'b0));
    end
    check_word("descriptor_fill_level", 32'(descriptor_fill_level), 32'd16);
    check_word("response_fill_level", 32'(response_fill_level), 32'd16);
    check_bit("descriptor_ready", descriptor_ready, 1'b0);  // queue is full
    check_bit("response_ready", response_ready, 1'b0);
    check_bit("block_address_ready", block_address_ready, 1'b0);
    check_bit("mem_write.write", mem_write.write, 1'b0);
    check_word("number of writes", 32'(log_addr.size() - first), 32'd0);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    check_word("descriptor_fill_level", 32'(descriptor_fill_level), 32'd0);
    check_word("response_fill_level", 32'(response_fill_level), 32'd0);
    finish_test("fill levels and flush", start);
  endtask

  // ********************************************************
  // main sequence
  // ********************************************************

  initial
  begin
    void'($urandom(32'hf50daff5));
    descriptor       = '0;
    descriptor_valid = 1'b0;
    response         = '0;
    response_valid   = 1'b0;
    sw_clear_irq     = 1'b0;
    irq_mask         = 1'b1;
    enable_store     = 1'b0;
    flush            = 1'b0;
    random_wait      = 1'b0;
    @(negedge reset);
    next_cycle();
    test_single_block();
    test_consecutive_blocks();
    test_back_pressure();
    test_pairing();
    test_interrupt();
    test_fill_and_flush();
    $display("tests run 6, tests failed %0d, errors %0d", tests_failed, total_errors());
    if (total_errors() == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+common
common/wb_pkg.sv
design/sync_fifo.sv
writeback/writeback_sequencer.sv
design/completion_irq.sv
design/desc_writeback_top.sv
testbench/tb_clock_gen.sv
testbench/desc_writeback_tb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = desc_writeback_tb
FILELIST   = project.f
BUILD_DIR  = obj_dir
LOG        = sim.log
VFLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
